// File: project.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/operand_extract.sv
rtl/op_classify.sv
rtl/decode_merge.sv
rtl/insn_decoder.sv
bench/tb_clock.sv
bench/insn_decoder_tb.sv

// File: bench/insn_decoder_tb.sv
`timescale 1ns/1ps

module insn_decoder_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int          RESET_LIMIT = 50;
    localparam logic [31:0] PC0         = 32'h1C00_0100;

    logic        clk;
    logic        reset;
    logic        insn_valid;
    insn_word_u  insn;
    logic [31:0] pc;
    fetch_excp_t fetch_excp;
    decode_out_t dec;

    string       names[$];
    logic [31:0] words[$];
    logic [31:0] pcs[$];
    logic [15:0] fexcs[$];
    logic        valids[$];
    decode_out_t exps[$];

    integer seed;
    int     pass_count;
    int     fail_count;
    logic   reset_ok;

    tb_clock clock_i (
        .clk (clk)
    );

    insn_decoder dut_i (
        .clk        (clk),
        .reset      (reset),
        .insn_valid (insn_valid),
        .insn       (insn),
        .pc         (pc),
        .fetch_excp (fetch_excp),
        .dec        (dec)
    );

    function automatic logic [31:0] r3_word(input logic [16:0] op, input reg_idx_t rk,
                                            input reg_idx_t rj, input reg_idx_t rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [11:0] imm,
                                              input reg_idx_t rj, input reg_idx_t rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] ri16_word(input logic [5:0] op, input logic [15:0] offs,
                                              input reg_idx_t rj, input reg_idx_t rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] ri20_word(input logic [6:0] op, input logic [19:0] imm,
                                              input reg_idx_t rd);
        return {op, imm, rd};
    endfunction

    // Offset bits 15:0 sit above bits 25:16
    function automatic logic [31:0] i26_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic ctrl_word_t alu_ctrl(input alu_op_e op, input src1_e s1, input src2_e s2);
        ctrl_word_t c;
        c = '0;
        c.unit      = UNIT_ALU;
        c.alu_op    = op;
        c.src1      = s1;
        c.src2      = s2;
        c.reg_write = 1'b1;
        return c;
    endfunction

    function automatic ctrl_word_t mem_ctrl(input mem_op_e op, input logic store);
        ctrl_word_t c;
        c = '0;
        c.unit      = UNIT_MEM;
        c.alu_op    = ALU_ADD;    // Address is rj + offset
        c.src2      = SRC2_IMM;
        c.reg_write = !store;
        c.mem_read  = !store;
        c.mem_write = store;
        c.mem_op    = op;
        return c;
    endfunction

    function automatic ctrl_word_t branch_ctrl(input br_cond_e cond, input alu_op_e op,
                                               input src2_e s2, input jump_kind_e kind);
        ctrl_word_t c;
        c = '0;
        c.unit     = UNIT_BRANCH;
        c.alu_op   = op;
        c.src2     = s2;
        c.br_cond  = cond;
        c.redirect = 1'b1;
        c.kind     = kind;
        return c;
    endfunction

    // Writes pc + 4 into rd
    function automatic ctrl_word_t link_ctrl(input jump_kind_e kind);
        ctrl_word_t c;
        c = '0;
        c.unit      = UNIT_BRANCH_LINK;
        c.alu_op    = ALU_ADD;
        c.src1      = SRC1_PC;
        c.src2      = SRC2_FOUR;
        c.reg_write = 1'b1;
        c.redirect  = 1'b1;
        c.kind      = kind;
        return c;
    endfunction

    function automatic decode_out_t valid_dec(input ctrl_word_t c, input reg_idx_t rj,
                                              input reg_idx_t rk, input reg_idx_t rd,
                                              input logic [31:0] imm);
        decode_out_t d;
        d = '0;
        d.valid   = 1'b1;
        d.ctrl    = c;
        d.ops.rj  = rj;
        d.ops.rk  = rk;
        d.ops.rd  = rd;
        d.ops.imm = imm;
        return d;
    endfunction

    function automatic decode_out_t excp_dec(input logic [15:0] arg);
        decode_out_t d;
        d = '0;
        d.valid     = 1'b1;
        d.ctrl.unit = UNIT_EXCEPTION;    // Operands stay zero
        d.excp_arg  = arg;
        return d;
    endfunction

    task automatic push_entry(input string name, input logic [31:0] word, input logic [31:0] p,
                              input logic [15:0] fexc, input logic v, input decode_out_t expected);
        names.push_back(name);
        words.push_back(word);
        pcs.push_back(p);
        fexcs.push_back(fexc);
        valids.push_back(v);
        exps.push_back(expected);
    endtask

    task automatic rr_alu_case(input string name, input logic [16:0] op, input alu_op_e alu);
        logic [31:0] rnd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        reg_idx_t    rd;
        rnd = $random(seed);
        rj  = rnd[4:0];
        rk  = rnd[9:5];
        rd  = rnd[14:10];
        push_entry(name, r3_word(op, rk, rj, rd), PC0, 16'h0, 1'b1,
                   valid_dec(alu_ctrl(alu, SRC1_REG, SRC2_REG), rj, rk, rd, 32'h0));
    endtask

    task automatic mem_case(input string name, input logic [9:0] op, input mem_op_e mop,
                            input logic store);
        push_entry(name, ri12_word(op, 12'hFF8, 5'd2, 5'd9), PC0, 16'h0, 1'b1,
                   valid_dec(mem_ctrl(mop, store), 5'd2, 5'd0, 5'd9, 32'hFFFF_FFF8));
    endtask

    task automatic branch_case(input string name, input logic [5:0] op, input br_cond_e cond,
                               input alu_op_e alu);
        push_entry(name, ri16_word(op, 16'hFFFE, 5'd4, 5'd5), PC0, 16'h0, 1'b1,
                   valid_dec(branch_ctrl(cond, alu, SRC2_BRANCH_REG, DIRECT_JUMP),
                             5'd4, 5'd0, 5'd5, 32'hFFFF_FFF8));
    endtask

    task automatic build_table();
        rr_alu_case("add_w", R3_ADD_W, ALU_ADD);
        rr_alu_case("sub_w", R3_SUB_W, ALU_SUB);
        rr_alu_case("slt", R3_SLT, ALU_SLT);
        rr_alu_case("sltu", R3_SLTU, ALU_SLTU);
        rr_alu_case("nor", R3_NOR, ALU_NOR);
        rr_alu_case("and", R3_AND, ALU_AND);
        rr_alu_case("or", R3_OR, ALU_OR);
        rr_alu_case("xor", R3_XOR, ALU_XOR);
        rr_alu_case("sll_w", R3_SLL_W, ALU_SLL);
        rr_alu_case("srl_w", R3_SRL_W, ALU_SRL);
        rr_alu_case("sra_w", R3_SRA_W, ALU_SRA);
        push_entry("slti", ri12_word(I12_SLTI, 12'hF00, 5'd3, 5'd4), PC0, 16'h0, 1'b1,
                   valid_dec(alu_ctrl(ALU_SLT, SRC1_REG, SRC2_IMM), 5'd3, 5'd0, 5'd4,
                             32'hFFFF_FF00));
        push_entry("addi_w", ri12_word(I12_ADDI_W, 12'h800, 5'd3, 5'd4), PC0, 16'h0, 1'b1,
                   valid_dec(alu_ctrl(ALU_ADD, SRC1_REG, SRC2_IMM), 5'd3, 5'd0, 5'd4,
                             32'hFFFF_F800));
        push_entry("andi", ri12_word(I12_ANDI, 12'hFFF, 5'd3, 5'd4), PC0, 16'h0, 1'b1,
                   valid_dec(alu_ctrl(ALU_AND, SRC1_REG, SRC2_IMM), 5'd3, 5'd0, 5'd4,
                             32'h0000_0FFF));    // Logical ops zero-extend
        push_entry("srai_w", r3_word(R3_SRAI_W, 5'h1F, 5'd3, 5'd4), PC0, 16'h0, 1'b1,
                   valid_dec(alu_ctrl(ALU_SRA, SRC1_REG, SRC2_IMM), 5'd3, 5'd0, 5'd4,
                             32'h0000_001F));
        push_entry("lu12i_w", ri20_word({OP_LU12I_W, 1'b0}, 20'h80001, 5'd6), PC0, 16'h0, 1'b1,
                   valid_dec(alu_ctrl(ALU_PASS_B, SRC1_REG, SRC2_IMM), 5'd0, 5'd0, 5'd6,
                             32'h8000_1000));
        push_entry("pcaddu12i", ri20_word({OP_PCADDU12I, 1'b0}, 20'hFFFFF, 5'd7), PC0, 16'h0,
                   1'b1, valid_dec(alu_ctrl(ALU_ADD, SRC1_PC, SRC2_IMM), 5'd0, 5'd0, 5'd7,
                                   32'hFFFF_F000));
        mem_case("ld_b", I12_LD_B, MEM_B, 1'b0);
        mem_case("ld_h", I12_LD_H, MEM_H, 1'b0);
        mem_case("ld_w", I12_LD_W, MEM_W, 1'b0);
        mem_case("ld_bu", I12_LD_BU, MEM_BU, 1'b0);
        mem_case("ld_hu", I12_LD_HU, MEM_HU, 1'b0);
        mem_case("st_b", I12_ST_B, MEM_B, 1'b1);
        mem_case("st_h", I12_ST_H, MEM_H, 1'b1);
        mem_case("st_w", I12_ST_W, MEM_W, 1'b1);
        // Equality by subtraction, ordering by set-less-than
        branch_case("beq", OP_BEQ, BR_EQ, ALU_SUB);
        branch_case("bne", OP_BNE, BR_NE, ALU_SUB);
        branch_case("blt", OP_BLT, BR_LT, ALU_SLT);
        branch_case("bge", OP_BGE, BR_GE, ALU_SLT);
        branch_case("bltu", OP_BLTU, BR_LTU, ALU_SLTU);
        branch_case("bgeu", OP_BGEU, BR_GEU, ALU_SLTU);
        push_entry("b", i26_word(OP_B, 26'h3FF_FFFF), PC0, 16'h0, 1'b1,
                   valid_dec(branch_ctrl(BR_ALWAYS, ALU_AND, SRC2_REG, JUMP),
                             5'd0, 5'd0, 5'd0, 32'hFFFF_FFFC));
        push_entry("bl", i26_word(OP_BL, 26'h000_0040), PC0, 16'h0, 1'b1,
                   valid_dec(link_ctrl(CALL), 5'd0, 5'd0, 5'd1, 32'h0000_0100));
        push_entry("jirl_ret", ri16_word(OP_JIRL, 16'h0, 5'd1, 5'd0), PC0, 16'h0, 1'b1,
                   valid_dec(link_ctrl(RET), 5'd1, 5'd0, 5'd0, 32'h0));
        push_entry("jirl_call", ri16_word(OP_JIRL, 16'h0010, 5'd12, 5'd1), PC0, 16'h0, 1'b1,
                   valid_dec(link_ctrl(CALL), 5'd12, 5'd0, 5'd1, 32'h0000_0040));
        push_entry("jirl_ind", ri16_word(OP_JIRL, 16'h8000, 5'd12, 5'd0), PC0, 16'h0, 1'b1,
                   valid_dec(link_ctrl(INDIRECT_JUMP), 5'd12, 5'd0, 5'd0, 32'hFFFE_0000));
        push_entry("fetch_over_adef", 32'hFFFF_FFFF, 32'h1C00_0102, 16'hFFFF, 1'b1,
                   excp_dec(16'h7FFF));    // Pending bit cleared in the argument
        push_entry("adef_over_ine", 32'hFFFF_FFFF, 32'h1C00_0101, 16'h0, 1'b1, excp_dec(16'h0008));
        push_entry("ine_opcode", 32'hFFFF_FFFF, PC0, 16'h0, 1'b1, excp_dec(16'h000D));
        push_entry("valid_low", r3_word(R3_ADD_W, 5'd1, 5'd2, 5'd3), PC0, 16'h0, 1'b0, '0);
        push_entry("adef_on_add", r3_word(R3_ADD_W, 5'd1, 5'd2, 5'd3), 32'h1C00_0103, 16'h0,
                   1'b1, excp_dec(16'h0008));
        push_entry("fetch_on_add", r3_word(R3_ADD_W, 5'd1, 5'd2, 5'd3), PC0, 16'h8005, 1'b1,
                   excp_dec(16'h0005));
        push_entry("break", r3_word(R3_BREAK, 5'd0, 5'd0, 5'd7), PC0, 16'h0, 1'b1,
                   excp_dec(16'h000C));
        push_entry("syscall", r3_word(R3_SYSCALL, 5'd0, 5'd0, 5'd3), PC0, 16'h0, 1'b1,
                   excp_dec(16'h000B));
        push_entry("mul_w", r3_word(17'h00038, 5'd1, 5'd2, 5'd3), PC0, 16'h0, 1'b1,
                   excp_dec(16'h000D));    // MUL.W, no longer supported
    endtask

    task automatic compare_dec(input string name, input decode_out_t expected,
                               input decode_out_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            fail_count++;
        end
        else
        begin
            $display("pass  %s", name);
            pass_count++;
        end
    endtask

    task automatic release_reset(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b1;
        while ((cycles < 4 || $isunknown(dec)) && ok)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_LIMIT)
                ok = 1'b0;
        end
        reset = 1'b0;
    endtask

    // One entry per cycle; each result is checked with the next entry already on the inputs
    task automatic run_table();
        int i;
        compare_dec("reset_clear", '0, dec);
        for (i = 0; i < names.size(); i++)
        begin
            @(negedge clk);
            insn_valid = valids[i];
            insn       = words[i];
            pc         = pcs[i];
            fetch_excp = fexcs[i];
            if (i > 0)
            begin
                #1;
                compare_dec(names[i-1], exps[i-1], dec);
            end
        end
        @(negedge clk);
        insn_valid = 1'b0;
        #1;
        compare_dec(names[names.size()-1], exps[names.size()-1], dec);
    endtask

    initial
    begin
        reset      = 1'b1;
        insn_valid = 1'b1;    // A valid word during reset must not reach dec
        insn       = r3_word(R3_ADD_W, 5'd1, 5'd2, 5'd3);
        pc         = PC0;
        fetch_excp = '0;
        seed       = 42732;
        pass_count = 0;
        fail_count = 0;
        build_table();
        release_reset(reset_ok);
        if (!reset_ok)
        begin
            $display("Timeout: decode bundle still unknown after %0d cycles of reset",
                     RESET_LIMIT);
            $display("Some tests failed");
            $finish;
        end
        else
        begin
            run_table();
            $display("%0d tests, %0d passed, %0d failed", pass_count + fail_count,
                     pass_count, fail_count);
            if (fail_count == 0)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;    // 4 ns period
    end

endmodule

// File: rtl/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  insn_valid,
    input  isa_pkg::insn_word_u   insn,
    input  logic [31:0]           pc,
    input  isa_pkg::fetch_excp_t  fetch_excp,
    output ctrl_pkg::decode_out_t dec
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    operands_t  ops_raw;
    ctrl_word_t ctrl_raw;
    ecode_t     excp_code;

    operand_extract operand_extract_i (
        .insn    (insn),
        .ops_raw (ops_raw)
    );

    op_classify op_classify_i (
        .insn      (insn),
        .ctrl_raw  (ctrl_raw),
        .excp_code (excp_code)
    );

    decode_merge decode_merge_i (
        .clk        (clk),
        .reset      (reset),
        .insn_valid (insn_valid),
        .pc         (pc),
        .fetch_excp (fetch_excp),
        .ctrl_raw   (ctrl_raw),
        .ops_raw    (ops_raw),
        .excp_code  (excp_code),
        .dec        (dec)
    );

endmodule

// File: rtl/decode_merge.sv
`timescale 1ns/1ps

module decode_merge (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  insn_valid,
    input  logic [31:0]           pc,
    input  isa_pkg::fetch_excp_t  fetch_excp,
    input  ctrl_pkg::ctrl_word_t  ctrl_raw,
    input  ctrl_pkg::operands_t   ops_raw,
    input  isa_pkg::ecode_t       excp_code,
    output ctrl_pkg::decode_out_t dec
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic        excp_taken;
    logic [15:0] excp_arg;
    decode_out_t dec_next;

    // Fetch fault first, then misaligned pc, then the decoded word
    always_comb
    begin
        excp_taken = 1'b1;
        if (fetch_excp.pending)
        begin
            excp_arg = {1'b0, fetch_excp.arg};
        end
        else if (|pc[1:0])
        begin
            excp_arg = {10'b0, ECODE_ADEF};
        end
        else
        begin
            excp_arg   = {10'b0, excp_code};
            excp_taken = (excp_code != ECODE_NONE);
        end
    end

    always_comb
    begin
        dec_next = '0;
        if (insn_valid)
        begin
            dec_next.valid    = 1'b1;
            dec_next.excp_arg = excp_arg;
            if (excp_taken)
            begin
                dec_next.ctrl.unit = UNIT_EXCEPTION;    // Operands stay zero
            end
            else
            begin
                dec_next.ctrl = ctrl_raw;
                dec_next.ops  = ops_raw;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            dec <= '0;
        else
            dec <= dec_next;
    end

endmodule

// File: rtl/op_classify.sv
`timescale 1ns/1ps

module op_classify (
    input  isa_pkg::insn_word_u  insn,
    output ctrl_pkg::ctrl_word_t ctrl_raw,
    output isa_pkg::ecode_t      excp_code
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    always_comb
    begin
        ctrl_raw  = '0;
        excp_code = ECODE_NONE;
        case (insn.ri16.opcode)
            OP_GRP0:
            begin
                ctrl_raw.unit      = UNIT_ALU;
                ctrl_raw.reg_write = 1'b1;
                // Only the 3R group has insn[25:22] zero
                ctrl_raw.src2 = (insn.ri12.opcode[3:0] == 4'b0000) ? SRC2_REG : SRC2_IMM;
                case (insn.r3.opcode)
                    R3_ADD_W:              ctrl_raw.alu_op = ALU_ADD;
                    R3_SUB_W:              ctrl_raw.alu_op = ALU_SUB;
                    R3_SLT:                ctrl_raw.alu_op = ALU_SLT;
                    R3_SLTU:               ctrl_raw.alu_op = ALU_SLTU;
                    R3_NOR:                ctrl_raw.alu_op = ALU_NOR;
                    R3_AND:                ctrl_raw.alu_op = ALU_AND;
                    R3_OR:                 ctrl_raw.alu_op = ALU_OR;
                    R3_XOR:                ctrl_raw.alu_op = ALU_XOR;
                    R3_SLL_W, R3_SLLI_W:   ctrl_raw.alu_op = ALU_SLL;
                    R3_SRL_W, R3_SRLI_W:   ctrl_raw.alu_op = ALU_SRL;
                    R3_SRA_W, R3_SRAI_W:   ctrl_raw.alu_op = ALU_SRA;
                    R3_BREAK:              excp_code = ECODE_BRK;
                    R3_SYSCALL:            excp_code = ECODE_SYS;
                    default:
                    begin
                        case (insn.ri12.opcode)
                            I12_SLTI:   ctrl_raw.alu_op = ALU_SLT;
                            I12_SLTUI:  ctrl_raw.alu_op = ALU_SLTU;
                            I12_ADDI_W: ctrl_raw.alu_op = ALU_ADD;
                            I12_ANDI:   ctrl_raw.alu_op = ALU_AND;
                            I12_ORI:    ctrl_raw.alu_op = ALU_OR;
                            I12_XORI:   ctrl_raw.alu_op = ALU_XOR;
                            default:    excp_code = ECODE_INE;    // MUL, DIV, RDCNT and the rest
                        endcase
                    end
                endcase
            end
            OP_LU12I_W:
            begin
                ctrl_raw.unit      = UNIT_ALU;
                ctrl_raw.alu_op    = ALU_PASS_B;
                ctrl_raw.src2      = SRC2_IMM;
                ctrl_raw.reg_write = 1'b1;
                if (insn.ri20.opcode[0])    // insn[25] must be clear
                    excp_code = ECODE_INE;
            end
            OP_PCADDU12I:
            begin
                ctrl_raw.unit      = UNIT_ALU;
                ctrl_raw.alu_op    = ALU_ADD;
                ctrl_raw.src1      = SRC1_PC;
                ctrl_raw.src2      = SRC2_IMM;
                ctrl_raw.reg_write = 1'b1;
                if (insn.ri20.opcode[0])
                    excp_code = ECODE_INE;
            end
            OP_MEM:
            begin
                ctrl_raw.unit   = UNIT_MEM;
                ctrl_raw.alu_op = ALU_ADD;    // Address rj + offset
                ctrl_raw.src2   = SRC2_IMM;
                case (insn.ri12.opcode)
                    I12_LD_B, I12_ST_B: ctrl_raw.mem_op = MEM_B;
                    I12_LD_H, I12_ST_H: ctrl_raw.mem_op = MEM_H;
                    I12_LD_W, I12_ST_W: ctrl_raw.mem_op = MEM_W;
                    I12_LD_BU:          ctrl_raw.mem_op = MEM_BU;
                    I12_LD_HU:          ctrl_raw.mem_op = MEM_HU;
                    default:            excp_code = ECODE_INE;    // PRELD too
                endcase
                // insn[24] set marks a store
                ctrl_raw.mem_write = insn.ri12.opcode[2];
                ctrl_raw.mem_read  = ~insn.ri12.opcode[2];
                ctrl_raw.reg_write = ~insn.ri12.opcode[2];
            end
            OP_JIRL:
            begin
                ctrl_raw.unit      = UNIT_BRANCH_LINK;
                ctrl_raw.alu_op    = ALU_ADD;
                ctrl_raw.src1      = SRC1_PC;
                ctrl_raw.src2      = SRC2_FOUR;
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.redirect  = 1'b1;
                if (insn.ri16.rd == 5'd0 && insn.ri16.rj == 5'd1 && insn.ri16.offs == 16'd0)
                    ctrl_raw.kind = RET;
                else if (insn.ri16.rd == 5'd1)
                    ctrl_raw.kind = CALL;
                else
                    ctrl_raw.kind = INDIRECT_JUMP;
            end
            OP_B:
            begin
                ctrl_raw.unit     = UNIT_BRANCH;
                ctrl_raw.redirect = 1'b1;
                ctrl_raw.kind     = JUMP;
            end
            OP_BL:
            begin
                ctrl_raw.unit      = UNIT_BRANCH_LINK;
                ctrl_raw.alu_op    = ALU_ADD;
                ctrl_raw.src1      = SRC1_PC;
                ctrl_raw.src2      = SRC2_FOUR;
                ctrl_raw.reg_write = 1'b1;
                ctrl_raw.redirect  = 1'b1;
                ctrl_raw.kind      = CALL;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
            begin
                ctrl_raw.unit     = UNIT_BRANCH;
                ctrl_raw.src2     = SRC2_BRANCH_REG;
                ctrl_raw.redirect = 1'b1;
                ctrl_raw.kind     = DIRECT_JUMP;
                case (insn.ri16.opcode)
                    OP_BEQ:  ctrl_raw.br_cond = BR_EQ;
                    OP_BNE:  ctrl_raw.br_cond = BR_NE;
                    OP_BLT:  ctrl_raw.br_cond = BR_LT;
                    OP_BGE:  ctrl_raw.br_cond = BR_GE;
                    OP_BLTU: ctrl_raw.br_cond = BR_LTU;
                    default: ctrl_raw.br_cond = BR_GEU;
                endcase
                case (insn.ri16.opcode)
                    OP_BEQ, OP_BNE: ctrl_raw.alu_op = ALU_SUB;
                    OP_BLT, OP_BGE: ctrl_raw.alu_op = ALU_SLT;
                    default:        ctrl_raw.alu_op = ALU_SLTU;
                endcase
            end
            default:
                excp_code = ECODE_INE;    // CSR, TLB, atomics, barriers
        endcase
    end

endmodule

// File: rtl/operand_extract.sv
`timescale 1ns/1ps

module operand_extract (
    input  isa_pkg::insn_word_u insn,
    output ctrl_pkg::operands_t ops_raw
);
    import isa_pkg::*;

    logic [31:0] simm12;
    logic [31:0] uimm12;
    logic [31:0] uimm20;
    logic [31:0] off16;
    logic [31:0] off26;

    assign simm12 = {{20{insn.ri12.imm[11]}}, insn.ri12.imm};
    assign uimm12 = {20'b0, insn.ri12.imm};
    assign uimm20 = {insn.ri20.imm, 12'b0};
    assign off16  = {{14{insn.ri16.offs[15]}}, insn.ri16.offs, 2'b00};
    assign off26  = {{4{insn.i26.offs_hi[9]}}, insn.i26.offs_hi, insn.i26.offs_lo, 2'b00};

    always_comb
    begin
        ops_raw = '0;
        case (insn.ri16.opcode)
            OP_GRP0:
            begin
                ops_raw.rj = insn.r3.rj;
                ops_raw.rd = insn.r3.rd;
                case (insn.ri12.opcode[3:0])    // insn[25:22] picks the format
                    4'b0000:                   ops_raw.rk  = insn.r3.rk;
                    4'b0001:                   ops_raw.imm = {27'b0, insn.r3.rk};  // ui5
                    4'b1000, 4'b1001, 4'b1010: ops_raw.imm = simm12;
                    4'b1101, 4'b1110, 4'b1111: ops_raw.imm = uimm12;
                    default:                   ops_raw     = '0;
                endcase
            end
            OP_LU12I_W, OP_PCADDU12I:
            begin
                ops_raw.rd  = insn.ri20.rd;
                ops_raw.imm = uimm20;
            end
            OP_MEM:
            begin
                ops_raw.rj  = insn.ri12.rj;
                ops_raw.rd  = insn.ri12.rd;    // Store data source on ST.*
                ops_raw.imm = simm12;
            end
            OP_JIRL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
            begin
                ops_raw.rj  = insn.ri16.rj;
                ops_raw.rd  = insn.ri16.rd;
                ops_raw.imm = off16;
            end
            OP_B:
                ops_raw.imm = off26;
            OP_BL:
            begin
                ops_raw.rd  = 5'd1;    // Link register ra
                ops_raw.imm = off26;
            end
            default:
                ops_raw = '0;
        endcase
    end

endmodule

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [2:0] {
        UNIT_ALU         = 3'd0,
        UNIT_BRANCH      = 3'd1,
        UNIT_BRANCH_LINK = 3'd2,
        UNIT_MEM         = 3'd3,
        UNIT_EXCEPTION   = 3'd4
    } unit_e;

    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_NOR    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_ADD    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_SLT    = 4'd9,
        ALU_SLTU   = 4'd10,
        ALU_PASS_B = 4'd12
    } alu_op_e;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } src1_e;

    typedef enum logic [1:0] {
        SRC2_REG        = 2'd0,
        SRC2_IMM        = 2'd1,
        SRC2_BRANCH_REG = 2'd2,    // rd read as compare operand
        SRC2_FOUR       = 2'd3     // Link address pc + 4
    } src2_e;

    typedef enum logic [2:0] {
        MEM_B  = 3'd0,
        MEM_H  = 3'd1,
        MEM_W  = 3'd2,
        MEM_BU = 3'd3,
        MEM_HU = 3'd4
    } mem_op_e;

    typedef enum logic [2:0] {
        BR_ALWAYS = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_LTU    = 3'd5,
        BR_GEU    = 3'd6
    } br_cond_e;

    // Hint for the branch predictor
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        JUMP          = 3'd2,
        CALL          = 3'd3,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5
    } jump_kind_e;

    typedef struct packed {
        unit_e      unit;
        alu_op_e    alu_op;
        src1_e      src1;
        src2_e      src2;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        mem_op_e    mem_op;
        br_cond_e   br_cond;
        logic       redirect;
        jump_kind_e kind;
    } ctrl_word_t;

    typedef struct packed {
        isa_pkg::reg_idx_t rj;
        isa_pkg::reg_idx_t rk;
        isa_pkg::reg_idx_t rd;
        logic [31:0]       imm;
    } operands_t;

    typedef struct packed {
        logic        valid;
        ctrl_word_t  ctrl;
        operands_t   ops;
        logic [15:0] excp_arg;
    } decode_out_t;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_ri12_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [13:0] imm;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_ri14_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm;
        reg_idx_t    rd;
    } fmt_ri20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;    // Top bits of the 26-bit offset
    } fmt_i26_t;

    // One fetched word, viewed per encoding format
    typedef union packed {
        fmt_3r_t   r3;
        fmt_ri12_t ri12;
        fmt_ri14_t ri14;
        fmt_ri16_t ri16;
        fmt_ri20_t ri20;
        fmt_i26_t  i26;
    } insn_word_u;

    // Major opcodes, insn[31:26]
    localparam logic [5:0] OP_GRP0      = 6'h00;
    localparam logic [5:0] OP_LU12I_W   = 6'h05;
    localparam logic [5:0] OP_PCADDU12I = 6'h07;
    localparam logic [5:0] OP_MEM       = 6'h0A;
    localparam logic [5:0] OP_JIRL      = 6'h13;
    localparam logic [5:0] OP_B         = 6'h14;
    localparam logic [5:0] OP_BL        = 6'h15;
    localparam logic [5:0] OP_BEQ       = 6'h16;
    localparam logic [5:0] OP_BNE       = 6'h17;
    localparam logic [5:0] OP_BLT       = 6'h18;
    localparam logic [5:0] OP_BGE       = 6'h19;
    localparam logic [5:0] OP_BLTU      = 6'h1A;
    localparam logic [5:0] OP_BGEU      = 6'h1B;

    // Full 17-bit opcodes, insn[31:15]
    localparam logic [16:0] R3_ADD_W   = 17'h00020;
    localparam logic [16:0] R3_SUB_W   = 17'h00022;
    localparam logic [16:0] R3_SLT     = 17'h00024;
    localparam logic [16:0] R3_SLTU    = 17'h00025;
    localparam logic [16:0] R3_NOR     = 17'h00028;
    localparam logic [16:0] R3_AND     = 17'h00029;
    localparam logic [16:0] R3_OR      = 17'h0002A;
    localparam logic [16:0] R3_XOR     = 17'h0002B;
    localparam logic [16:0] R3_SLL_W   = 17'h0002E;
    localparam logic [16:0] R3_SRL_W   = 17'h0002F;
    localparam logic [16:0] R3_SRA_W   = 17'h00030;
    localparam logic [16:0] R3_BREAK   = 17'h00054;
    localparam logic [16:0] R3_SYSCALL = 17'h00056;
    localparam logic [16:0] R3_SLLI_W  = 17'h00081;
    localparam logic [16:0] R3_SRLI_W  = 17'h00089;
    localparam logic [16:0] R3_SRAI_W  = 17'h00091;

    // Full 10-bit opcodes, insn[31:22]
    localparam logic [9:0] I12_SLTI   = 10'h008;
    localparam logic [9:0] I12_SLTUI  = 10'h009;
    localparam logic [9:0] I12_ADDI_W = 10'h00A;
    localparam logic [9:0] I12_ANDI   = 10'h00D;
    localparam logic [9:0] I12_ORI    = 10'h00E;
    localparam logic [9:0] I12_XORI   = 10'h00F;
    localparam logic [9:0] I12_LD_B   = 10'h0A0;
    localparam logic [9:0] I12_LD_H   = 10'h0A1;
    localparam logic [9:0] I12_LD_W   = 10'h0A2;
    localparam logic [9:0] I12_ST_B   = 10'h0A4;
    localparam logic [9:0] I12_ST_H   = 10'h0A5;
    localparam logic [9:0] I12_ST_W   = 10'h0A6;
    localparam logic [9:0] I12_LD_BU  = 10'h0A8;
    localparam logic [9:0] I12_LD_HU  = 10'h0A9;

    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_SYS  = 6'h0B,
        ECODE_BRK  = 6'h0C,
        ECODE_INE  = 6'h0D
    } ecode_t;

    typedef struct packed {
        logic        pending;
        logic [14:0] arg;
    } fetch_excp_t;

endpackage
